// File: include/commit_params.svh
`ifndef COMMIT_PARAMS_SVH
`define COMMIT_PARAMS_SVH

// ---------------------------------------------------------------------------
// Stream geometry
// ---------------------------------------------------------------------------

// Width of one stream beat, which also holds one full request header
`define COMMIT_DATA_W 128

// Side-band bits that travel with every beat
// Bit 0 selects the data-mover header layout when set
`define COMMIT_USER_W 1

// ---------------------------------------------------------------------------
// Format and type codes
// ---------------------------------------------------------------------------

// Memory write request with a 64-bit address
// Only this code produces a commit
`define FMT_MWR 8'h60

// Completion without data, the code placed in every generated commit
`define FMT_CPL 8'h0A

// ---------------------------------------------------------------------------
// Commit path buffering
// ---------------------------------------------------------------------------

// Entries in the commit skid buffer
// The tracker relies on at least two, one in flight and one waiting
`define COMMIT_SKID_DEPTH 2

`endif

// File: logic/commit_pkg.sv
package commit_pkg;

`include "commit_params.svh"

   // -------------------------------------------------------------------------
   // Field types
   // -------------------------------------------------------------------------

   // Format and type code, always the top byte of a header beat
   typedef logic [7:0] fmt_t;

   // Length in dwords, zero means the largest transfer
   typedef logic [9:0] len_t;

   typedef logic [9:0] tag_t;
   typedef logic [15:0] req_id_t;

   // Function number packed as {pf_num[2:0], vf_num[10:0], vf_active}
   typedef logic [14:0] func_t;

   // Completion byte count, four times the dword length
   typedef logic [11:0] byte_cnt_t;

   typedef logic [`COMMIT_USER_W-1:0] user_t;
   typedef logic [`COMMIT_DATA_W-1:0] data_t;
   typedef logic [`COMMIT_DATA_W/8-1:0] keep_t;

   // -------------------------------------------------------------------------
   // Request header views
   // -------------------------------------------------------------------------

   // Data-mover request, without a requester id
   typedef struct packed {
      fmt_t        fmt;
      tag_t        tag;
      len_t        len;
      func_t       func;
      logic [20:0] rsvd;
      logic [63:0] host_addr;
   } dm_req_hdr_t;

   // Port-unit request, which carries the requester id
   typedef struct packed {
      fmt_t        fmt;
      tag_t        tag;
      len_t        len;
      req_id_t     req_id;
      func_t       func;
      logic [4:0]  rsvd;
      logic [63:0] host_addr;
   } pu_req_hdr_t;

   // -------------------------------------------------------------------------
   // Completion header views
   // -------------------------------------------------------------------------

   // Data-mover completion, fc marks the final completion of a request
   typedef struct packed {
      fmt_t        fmt;
      tag_t        tag;
      len_t        len;
      func_t       func;
      logic        fc;
      logic [83:0] rsvd;
   } dm_cpl_hdr_t;

   typedef struct packed {
      fmt_t        fmt;
      tag_t        tag;
      len_t        len;
      req_id_t     req_id;
      func_t       func;
      byte_cnt_t   byte_cnt;
      logic [56:0] rsvd;
   } pu_cpl_hdr_t;

   // One beat on any of the three streams
   typedef struct packed {
      data_t data;
      keep_t keep;
      logic  last;
      user_t dm_mode;
   } stream_beat_t;

   // Tracker position within the packet stream
   typedef enum logic [1:0] {
      IDLE_SOP,
      IN_WRITE,
      IN_OTHER,
      COMMIT_WAIT
   } tracker_state_t;

endpackage

// File: logic/commit_tracker.sv
`timescale 1ns/10ps
`include "commit_params.svh"

module commit_tracker (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     sink_valid,
   input  commit_pkg::stream_beat_t sink_beat,
   output logic                     sink_ready,
   output logic                     source_valid,
   input  logic                     source_ready,
   input  logic                     cmt_in_ready,
   output logic                     cmt_in_valid,
   output logic                     capture
);

   import commit_pkg::*;

   tracker_state_t state;
   tracker_state_t state_next;
   dm_req_hdr_t    hdr_view;
   logic           at_sop;
   logic           is_write;
   logic           ends_write;
   logic           end_ok;
   logic           xfer;

   // ---------------------------------------------------------------------------
   // Beat classification
   // ---------------------------------------------------------------------------

   // Both layouts keep the format code in the top byte, so either view works
   assign hdr_view = dm_req_hdr_t'(sink_beat.data);

   // The cycle after a commit is raised is also a packet boundary
   assign at_sop = (state == IDLE_SOP) || (state == COMMIT_WAIT);
   assign is_write = at_sop && (hdr_view.fmt == fmt_t'(`FMT_MWR));

   // This beat closes a write and would push another commit
   assign ends_write = sink_beat.last && (is_write || (state == IN_WRITE));

   // A closing beat needs room in the skid buffer and no push this cycle
   // Payload and read beats never wait for the commit path
   // Once raised this stays high while the beat is stalled, since no push
   // can happen without a transfer here
   assign end_ok = !ends_write || (cmt_in_ready && !cmt_in_valid);

   assign sink_ready   = source_ready && end_ok;
   assign source_valid = sink_valid && end_ok;
   assign xfer         = sink_valid && sink_ready;

   // Header generator latches on the accepted first beat of a write
   assign capture = xfer && is_write;

   // One cycle in COMMIT_WAIT is exactly one push into the skid buffer
   assign cmt_in_valid = (state == COMMIT_WAIT);

   // ---------------------------------------------------------------------------
   // Packet FSM
   // ---------------------------------------------------------------------------

   always_comb begin
      state_next = state;
      case (state)
         IDLE_SOP, COMMIT_WAIT: begin
            // Leave COMMIT_WAIT after one cycle even without a new packet
            state_next = IDLE_SOP;
            if (xfer) begin
               if (is_write) begin
                  state_next = sink_beat.last ? COMMIT_WAIT : IN_WRITE;
               end else begin
                  state_next = sink_beat.last ? IDLE_SOP : IN_OTHER;
               end
            end
         end
         IN_WRITE: begin
            if (xfer && sink_beat.last) begin
               state_next = COMMIT_WAIT;
            end
         end
         IN_OTHER: begin
            if (xfer && sink_beat.last) begin
               state_next = IDLE_SOP;
            end
         end
         default: begin
            state_next = IDLE_SOP;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= IDLE_SOP;
      end else begin
         state <= state_next;
      end
   end

endmodule

// File: logic/commit_hdr_gen.sv
`timescale 1ns/10ps
`include "commit_params.svh"

module commit_hdr_gen (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     capture,
   input  commit_pkg::stream_beat_t sink_beat,
   output commit_pkg::stream_beat_t cpl_beat
);

   import commit_pkg::*;

   dm_req_hdr_t  dm_req;
   pu_req_hdr_t  pu_req;
   dm_cpl_hdr_t  dm_cpl;
   pu_cpl_hdr_t  pu_cpl;
   stream_beat_t cpl_next;

   // The same header beat seen through both layouts
   assign dm_req = dm_req_hdr_t'(sink_beat.data);
   assign pu_req = pu_req_hdr_t'(sink_beat.data);

   // ---------------------------------------------------------------------------
   // Completion forming
   // ---------------------------------------------------------------------------

   always_comb begin
      // Data-mover completion mirrors the request and closes it with fc
      dm_cpl      = '0;
      dm_cpl.fmt  = fmt_t'(`FMT_CPL);
      dm_cpl.tag  = dm_req.tag;
      dm_cpl.len  = dm_req.len;
      dm_cpl.func = dm_req.func;
      dm_cpl.fc   = 1'b1;

      // Port-unit completion also returns the requester id
      pu_cpl        = '0;
      pu_cpl.fmt    = fmt_t'(`FMT_CPL);
      pu_cpl.tag    = pu_req.tag;
      pu_cpl.len    = pu_req.len;
      pu_cpl.req_id = pu_req.req_id;
      pu_cpl.func   = pu_req.func;
      // Byte count is four bytes per dword
      // A zero length wraps to zero here, as the link expects for 4 KB
      pu_cpl.byte_cnt = byte_cnt_t'({pu_req.len, 2'b00});

      // The commit is one complete beat tagged with the request's layout
      cpl_next.data    = sink_beat.dm_mode[0] ? data_t'(dm_cpl) : data_t'(pu_cpl);
      cpl_next.keep    = '1;
      cpl_next.last    = 1'b1;
      cpl_next.dm_mode = sink_beat.dm_mode;
   end

   // ---------------------------------------------------------------------------
   // Holding register
   // ---------------------------------------------------------------------------

   // Held until the next write starts, which may be long after the header
   // beat, since the commit is only pushed once the payload has passed
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cpl_beat <= '0;
      end else if (capture) begin
         cpl_beat <= cpl_next;
      end
   end

endmodule

// File: logic/commit_skid.sv
`timescale 1ns/10ps
`include "commit_params.svh"

module commit_skid (
   input  logic                     clk,
   input  logic                     rst_n,
   input  commit_pkg::stream_beat_t in_beat,
   input  logic                     in_valid,
   output logic                     in_ready,
   output commit_pkg::stream_beat_t out_beat,
   output logic                     out_valid,
   input  logic                     out_ready
);

   import commit_pkg::*;

   localparam int DEPTH = `COMMIT_SKID_DEPTH;
   localparam int CNT_W = $clog2(DEPTH + 1);

   // Head entry drives the output directly, the skid entry queues behind it
   stream_beat_t     main_q;
   stream_beat_t     skid_q;
   logic [CNT_W-1:0] count;
   logic [CNT_W-1:0] count_next;
   logic             push;
   logic             pop;

   assign push = in_valid && in_ready;
   assign pop  = out_valid && out_ready;

   assign out_beat = main_q;

   // ---------------------------------------------------------------------------
   // Occupancy
   // ---------------------------------------------------------------------------

   always_comb begin
      count_next = count;
      if (push && !pop) begin
         count_next = count + CNT_W'(1);
      end else if (pop && !push) begin
         count_next = count - CNT_W'(1);
      end
   end

   // Both handshake flags come straight from flops
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         count     <= '0;
         out_valid <= 1'b0;
         in_ready  <= 1'b1;
      end else begin
         count     <= count_next;
         out_valid <= (count_next != '0);
         in_ready  <= (count_next < CNT_W'(DEPTH));
      end
   end

   // ---------------------------------------------------------------------------
   // Entry storage
   // ---------------------------------------------------------------------------

   always_ff @(posedge clk) begin
      // New data goes to the head when the head is free or leaving now
      if (push && ((count == '0) || ((count == CNT_W'(1)) && pop))) begin
         main_q <= in_beat;
      end else if (pop && (count == CNT_W'(2))) begin
         main_q <= skid_q;
      end

      // Second entry only fills while the head is stuck
      if (push && (count == CNT_W'(1)) && !pop) begin
         skid_q <= in_beat;
      end
   end

endmodule

// File: logic/local_commit_top.sv
`timescale 1ns/10ps

module local_commit_top (
   input  logic                     clk,
   input  logic                     rst_n,

   // Request stream from the requester
   input  commit_pkg::stream_beat_t sink_beat,
   input  logic                     sink_valid,
   output logic                     sink_ready,

   // Same stream toward the host link
   output commit_pkg::stream_beat_t source_beat,
   output logic                     source_valid,
   input  logic                     source_ready,

   // Locally generated completions
   output commit_pkg::stream_beat_t commit_beat,
   output logic                     commit_valid,
   input  logic                     commit_ready
);

   import commit_pkg::*;

   stream_beat_t cpl_beat;
   logic         capture;
   logic         cmt_in_valid;
   logic         cmt_in_ready;

   // Payload passes untouched, only the handshake is gated by the tracker
   assign source_beat = sink_beat;

   // ---------------------------------------------------------------------------
   // Submodules
   // ---------------------------------------------------------------------------

   commit_tracker commit_tracker_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .sink_valid   (sink_valid),
      .sink_beat    (sink_beat),
      .sink_ready   (sink_ready),
      .source_valid (source_valid),
      .source_ready (source_ready),
      .cmt_in_ready (cmt_in_ready),
      .cmt_in_valid (cmt_in_valid),
      .capture      (capture)
   );

   commit_hdr_gen commit_hdr_gen_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .capture   (capture),
      .sink_beat (sink_beat),
      .cpl_beat  (cpl_beat)
   );

   // Decouples commit back-pressure from the stream by two entries
   commit_skid commit_skid_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_beat   (cpl_beat),
      .in_valid  (cmt_in_valid),
      .in_ready  (cmt_in_ready),
      .out_beat  (commit_beat),
      .out_valid (commit_valid),
      .out_ready (commit_ready)
   );

endmodule

// File: testbench/local_commit_chk.sv
`timescale 1ns/10ps

module local_commit_chk (
   input logic                     clk,
   input logic                     rst_n,
   input commit_pkg::stream_beat_t sink_beat,
   input logic                     sink_valid,
   input logic                     sink_ready,
   input commit_pkg::stream_beat_t source_beat,
   input logic                     source_valid,
   input logic                     source_ready,
   input commit_pkg::stream_beat_t commit_beat,
   input logic                     commit_valid,
   input logic                     commit_ready,
   input logic                     cmt_in_valid,
   input logic                     cmt_in_ready
);

   // Failure count, read by the testbench for its closing report
   int assert_errs = 0;

   // ---------------------------------------------------------------------------
   // Stream stability while stalled
   // ---------------------------------------------------------------------------

   sink_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (sink_valid && !sink_ready) |=> (sink_valid && $stable(sink_beat)))
      else begin
         assert_errs++;
         $error("Sink beat dropped or changed while stalled");
      end

   source_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (source_valid && !source_ready) |=> (source_valid && $stable(source_beat)))
      else begin
         assert_errs++;
         $error("Source beat dropped or changed while stalled");
      end

   commit_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (commit_valid && !commit_ready) |=> (commit_valid && $stable(commit_beat)))
      else begin
         assert_errs++;
         $error("Commit beat dropped or changed while stalled");
      end

   // ---------------------------------------------------------------------------
   // Commit path
   // ---------------------------------------------------------------------------

   // Reset clears the skid buffer output on the same edge
   commit_reset: assert property (@(posedge clk) !rst_n |=> !commit_valid)
      else begin
         assert_errs++;
         $error("Commit valid high after reset");
      end

   // The tracker may only push into a skid buffer with room
   push_room: assert property (@(posedge clk) disable iff (!rst_n)
      cmt_in_valid |-> cmt_in_ready)
      else begin
         assert_errs++;
         $error("Commit pushed into a full skid buffer");
      end

   // A pushed commit shows up on the output one cycle later at the latest
   push_visible: assert property (@(posedge clk) disable iff (!rst_n)
      cmt_in_valid |=> commit_valid)
      else begin
         assert_errs++;
         $error("Pushed commit did not reach the output");
      end

endmodule

// File: testbench/local_commit_tb.sv
`timescale 1ns/10ps
`include "commit_params.svh"

module local_commit_tb;

   import commit_pkg::*;

   // One packet as described by a line of the stimulus file
   typedef struct packed {
      logic [7:0] test;
      logic       mode;
      fmt_t       fmt;
      len_t       len;
      tag_t       tag;
      req_id_t    req_id;
      func_t      func;
      logic [7:0] beats;
      logic       cmt;
   } pkt_t;

   logic         clk;
   logic         rst_n;
   stream_beat_t sink_beat;
   logic         sink_valid;
   logic         sink_ready;
   stream_beat_t source_beat;
   logic         source_valid;
   logic         source_ready;
   stream_beat_t commit_beat;
   logic         commit_valid;
   logic         commit_ready;

   pkt_t         pkts[$];
   stream_beat_t src_q[$];
   stream_beat_t cpl_q[$];
   int           cpl_cyc_q[$];
   int           cycle = 0;
   int           cur_test = 0;
   int           hold_left = 0;
   int           stall_cnt = 0;
   int           checks = 0;
   int           errors = 0;
   int           test_errs = 0;
   int           tests_run = 0;
   int           total_beats = 0;
   logic         stim_loaded = 1'b0;

   local_commit_top local_commit_top_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .sink_beat    (sink_beat),
      .sink_valid   (sink_valid),
      .sink_ready   (sink_ready),
      .source_beat  (source_beat),
      .source_valid (source_valid),
      .source_ready (source_ready),
      .commit_beat  (commit_beat),
      .commit_valid (commit_valid),
      .commit_ready (commit_ready)
   );

   bind local_commit_top local_commit_chk local_commit_chk_i (
      .clk (clk), .rst_n (rst_n),
      .sink_beat (sink_beat), .sink_valid (sink_valid), .sink_ready (sink_ready),
      .source_beat (source_beat), .source_valid (source_valid),
      .source_ready (source_ready),
      .commit_beat (commit_beat), .commit_valid (commit_valid),
      .commit_ready (commit_ready),
      .cmt_in_valid (cmt_in_valid), .cmt_in_ready (cmt_in_ready)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
   end

   // ---------------------------------------------------------------------------
   // Checking helpers
   // ---------------------------------------------------------------------------

   task automatic compare(input logic [159:0] got, input logic [159:0] exp,
                          input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         test_errs++;
         $display("FAILED at %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic note_problem(input string what);
      errors++;
      test_errs++;
      $display("%s at %0d ns", what, $time);
   endtask

   // ---------------------------------------------------------------------------
   // Stimulus file and reference model
   // ---------------------------------------------------------------------------

   task automatic load_stim();
      int    fd;
      int    n;
      int    t, m, f, l, tg, rq, fn, b, c;
      string line;
      pkt_t  p;
      fd = $fopen("testbench/commit_stim.txt", "r");
      if (fd == 0) begin
         note_problem("Cannot open the stimulus file testbench/commit_stim.txt");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // Lines starting with a hash are comments and short lines are blank
            if (n > 0 && line.len() > 4 && line.getc(0) != "#") begin
               n = $sscanf(line, "%d %d %h %h %h %h %h %d %d",
                           t, m, f, l, tg, rq, fn, b, c);
               if (n == 9) begin
                  p.test   = t[7:0];
                  p.mode   = m[0];
                  p.fmt    = f[7:0];
                  p.len    = l[9:0];
                  p.tag    = tg[9:0];
                  p.req_id = rq[15:0];
                  p.func   = fn[14:0];
                  p.beats  = b[7:0];
                  p.cmt    = c[0];
                  pkts.push_back(p);
                  total_beats += b;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // Header beat in the chosen layout with noise in the unused fields
   function automatic data_t header_data(input pkt_t p);
      dm_req_hdr_t dm;
      pu_req_hdr_t pu;
      dm = {$urandom, $urandom, $urandom, $urandom};
      pu = {$urandom, $urandom, $urandom, $urandom};
      dm.fmt    = p.fmt;
      dm.tag    = p.tag;
      dm.len    = p.len;
      dm.func   = p.func;
      pu.fmt    = p.fmt;
      pu.tag    = p.tag;
      pu.len    = p.len;
      pu.req_id = p.req_id;
      pu.func   = p.func;
      return p.mode ? data_t'(dm) : data_t'(pu);
   endfunction

   // Completion a write should produce with all reserved bits zero
   function automatic stream_beat_t expect_commit(input pkt_t p);
      dm_cpl_hdr_t  dm;
      pu_cpl_hdr_t  pu;
      stream_beat_t b;
      int           bytes;
      dm      = '0;
      dm.fmt  = `FMT_CPL;
      dm.tag  = p.tag;
      dm.len  = p.len;
      dm.func = p.func;
      dm.fc   = 1'b1;
      // The byte count is four per dword and keeps only its low 12 bits
      bytes       = 4 * p.len;
      pu          = '0;
      pu.fmt      = `FMT_CPL;
      pu.tag      = p.tag;
      pu.len      = p.len;
      pu.req_id   = p.req_id;
      pu.func     = p.func;
      pu.byte_cnt = bytes[11:0];
      b.data    = p.mode ? data_t'(dm) : data_t'(pu);
      b.keep    = '1;
      b.last    = 1'b1;
      b.dm_mode = p.mode;
      return b;
   endfunction

   task automatic send_packet(input pkt_t p);
      stream_beat_t beat;
      int           i;
      for (i = 0; i < p.beats; i++) begin
         beat.data    = (i == 0) ? header_data(p) : {$urandom, $urandom, $urandom, $urandom};
         beat.keep    = '1;
         beat.last    = (i == p.beats - 1);
         beat.dm_mode = p.mode;
         src_q.push_back(beat);
         @(negedge clk);
         sink_valid = 1'b1;
         sink_beat  = beat;
         @(posedge clk);
         while (!sink_ready) begin
            @(posedge clk);
         end
      end
      // Last beat has just transferred, so the commit is now owed
      if (p.cmt) begin
         cpl_q.push_back(expect_commit(p));
         cpl_cyc_q.push_back(cycle);
      end
   endtask

   // ---------------------------------------------------------------------------
   // Back-pressure and monitors
   // ---------------------------------------------------------------------------

   // Both outputs stall about 30% of the time except in the first test
   always @(negedge clk) begin
      if (cur_test <= 1) begin
         source_ready = 1'b1;
         commit_ready = 1'b1;
      end else begin
         source_ready = ($urandom_range(99) >= 30);
         if (hold_left > 0) begin
            commit_ready = 1'b0;
            hold_left--;
         end else begin
            commit_ready = ($urandom_range(99) >= 30);
         end
      end
   end

   always @(posedge clk) begin : watch_outputs
      stream_beat_t exp_cpl;
      int           exp_cyc;
      if (rst_n) begin
         compare(source_valid && source_ready, sink_valid && sink_ready,
                 "source and sink transfer together");
         if (source_valid && source_ready) begin
            if (src_q.size() == 0) begin
               note_problem("Source beat appeared with no sink beat sent");
            end else begin
               compare(source_beat, src_q.pop_front(), "source beat");
            end
         end
         if (commit_valid && commit_ready) begin
            if (cpl_q.size() == 0) begin
               note_problem("Commit appeared with no write outstanding");
            end else begin
               exp_cpl = cpl_q.pop_front();
               exp_cyc = cpl_cyc_q.pop_front();
               compare(commit_beat, exp_cpl, "commit beat");
               // Without stalls the commit leaves two edges after the last beat
               if (cur_test == 1) begin
                  compare(cycle - exp_cyc, 2, "commit latency in cycles");
               end
            end
         end
         if (cur_test == 5 && sink_valid && !sink_ready && source_ready) begin
            stall_cnt++;
         end
      end
   end

   always @(negedge clk) begin
      if (rst_n && cpl_q.size() > `COMMIT_SKID_DEPTH) begin
         note_problem("More commits outstanding than the skid buffer holds");
      end
   end

   // ---------------------------------------------------------------------------
   // Test sequence
   // ---------------------------------------------------------------------------

   initial begin : main_flow
      int idx;
      int p_cnt;
      int c_cnt;
      rst_n        = 1'b0;
      sink_valid   = 1'b0;
      sink_beat    = '0;
      source_ready = 1'b1;
      commit_ready = 1'b1;
      void'($urandom(11620));
      load_stim();
      stim_loaded = 1'b1;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      idx = 0;
      while (idx < pkts.size()) begin
         cur_test  = pkts[idx].test;
         test_errs = 0;
         stall_cnt = 0;
         p_cnt     = 0;
         c_cnt     = 0;
         // Test 5 holds the commit output long enough to fill the skid buffer
         if (cur_test == 5) begin
            hold_left = 60;
         end
         while (idx < pkts.size() && pkts[idx].test == cur_test) begin
            send_packet(pkts[idx]);
            c_cnt += pkts[idx].cmt;
            p_cnt++;
            idx++;
         end
         @(negedge clk);
         sink_valid = 1'b0;
         while (src_q.size() != 0 || cpl_q.size() != 0) begin
            @(negedge clk);
         end
         if (cur_test == 5) begin
            compare(stall_cnt > 0, 1, "sink stalled while commits were held");
         end
         $display("Test %0d finished: %0d packets, %0d commits, %0d errors",
                  cur_test, p_cnt, c_cnt, test_errs);
         tests_run++;
      end
      errors += local_commit_top_i.local_commit_chk_i.assert_errs;
      $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // Allows 40 cycles per stimulus beat plus the reset
   initial begin : watchdog
      int limit;
      wait (stim_loaded);
      limit = 40 * total_beats + 8;
      repeat (limit) @(posedge clk);
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("Test failed");
      $finish;
   end

endmodule

// File: testbench/commit_stim.txt
# test mode(1=data-mover) fmt(hex) len(hex) tag(hex) req_id(hex) func(hex) beats commit
# beats counts the header beat; commit is 1 when the packet must produce a completion
1 0 60 001 001 0100 0000 1 1
1 1 60 004 002 0000 1a2b 1 1
1 0 20 008 003 0100 0000 1 0
1 0 60 010 004 0200 0003 3 1
1 1 60 002 005 0000 4001 1 1
1 0 60 003 006 0300 0005 1 1
2 0 60 000 010 1234 7fff 2 1
2 0 60 3ff 3ff ffff 0001 4 1
2 0 60 155 2aa 8001 5555 2 1
2 0 60 0aa 155 00ff 2aaa 1 1
2 0 60 100 07f abcd 1001 3 1
2 0 60 001 200 0001 0000 1 1
3 1 60 020 011 0000 0123 2 1
3 1 20 040 012 0000 0124 1 0
3 1 60 3ff 3fe 0000 7ffe 3 1
3 0 40 004 013 0500 0000 2 0
3 1 0a 001 014 0000 0011 1 0
3 1 60 000 015 0000 4444 1 1
3 0 20 010 016 0600 0002 1 0
4 0 60 010 020 0700 0010 4 1
4 1 20 008 021 0000 0011 1 0
4 1 60 018 022 0000 0012 5 1
4 0 20 002 023 0800 0013 1 0
4 0 60 004 024 0900 0014 2 1
4 1 60 00c 025 0000 0015 3 1
4 0 40 003 026 0a00 0016 2 0
4 1 60 001 027 0000 0017 1 1
5 0 60 001 030 0b00 0020 1 1
5 1 60 002 031 0000 0021 1 1
5 0 60 003 032 0c00 0022 2 1
5 1 20 004 033 0000 0023 1 0
5 0 60 005 034 0d00 0024 1 1
5 1 60 006 035 0000 0025 2 1
5 0 60 007 036 0e00 0026 1 1
5 1 60 008 037 0000 0027 1 1
5 0 60 009 038 0f00 0028 3 1
5 1 60 00a 039 0000 0029 1 1

// File: sim.f
+incdir+include
logic/commit_pkg.sv
logic/commit_tracker.sv
logic/commit_hdr_gen.sv
logic/commit_skid.sv
logic/local_commit_top.sv
testbench/local_commit_chk.sv
testbench/local_commit_tb.sv
